//--- rtl/fpu_pkg.sv
package fpu_pkg;

  // single-precision word layout
  localparam int word_w   = 32;
  localparam int exp_w    = 8;
  localparam int man_w    = 23;
  localparam int sign_bit = word_w - 1;
  localparam int exp_lsb  = man_w;

  // all-ones exponent, infinity
  localparam int exp_max = 255;

  // peer units on the shared writeback port
  localparam int unit_n = 2;

  // unit tags, used on op and result_tag
  localparam logic tag_add = 1'b0;
  localparam logic tag_mul = 1'b1;

  // cycles from accepting edge to done
  localparam int fadd_stages = 3;
  localparam int fmul_stages = 2;

endpackage

//--- rtl/fadd.sv
`timescale 1ns/1ps

module fadd
  import fpu_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              order,
  output logic              accepted,
  output logic              done,
  input  logic              grant,
  input  logic [word_w-1:0] rs1,
  input  logic [word_w-1:0] rs2,
  output logic [word_w-1:0] rd
);

  logic       busy;
  logic [1:0] cnt;
  logic       ld2;
  logic       ld3;

  assign accepted = ~busy & order;
  assign done     = busy & (cnt == 2'(fadd_stages - 1));
  assign ld2      = busy & (cnt == 2'd0);
  assign ld3      = busy & (cnt == 2'd1);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (accepted) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (done) begin
      // sit on the result until the arbiter takes it
      if (grant) begin
        busy <= 1'b0;
        cnt  <= '0;
      end
    end else if (busy) begin
      cnt <= cnt + 2'd1;
    end
  end

  // position of the leading one, counted from bit 25
  function automatic logic [4:0] lead_shift(input logic [26:0] m);
    logic [4:0] sh;
    sh = 5'd26;
    for (int i = 0; i <= 25; i++) begin
      if (m[i]) begin
        sh = 5'(25 - i);
      end
    end
    return sh;
  endfunction

  // stage one: align
  logic [exp_w-1:0] e1;
  logic [exp_w-1:0] e2;
  logic [exp_w-1:0] e1a;
  logic [exp_w-1:0] e2a;
  logic [man_w+1:0] m1a;
  logic [man_w+1:0] m2a;
  logic [exp_w:0]   te;
  logic [exp_w-1:0] tde;
  logic [4:0]       de;
  logic             sel;
  logic [man_w+1:0] ms;
  logic [man_w+1:0] mi;
  logic [exp_w-1:0] es;
  logic             ss;
  logic [55:0]      mia;

  assign e1  = rs1[exp_lsb +: exp_w];
  assign e2  = rs2[exp_lsb +: exp_w];
  // zero exponent counts as one, no hidden bit
  assign e1a = (e1 == '0) ? exp_w'(1) : e1;
  assign e2a = (e2 == '0) ? exp_w'(1) : e2;
  assign m1a = {1'b0, (e1 != '0), rs1[man_w-1:0]};
  assign m2a = {1'b0, (e2 != '0), rs2[man_w-1:0]};

  // e1a - e2a - 1, top bit set when e1a is larger
  assign te  = {1'b0, e1a} + {1'b0, ~e2a};
  assign tde = te[exp_w] ? (te[exp_w-1:0] + 1'b1) : ~te[exp_w-1:0];
  assign de  = (tde > 8'd31) ? 5'd31 : tde[4:0];
  assign sel = (de == 5'd0) ? (m2a >= m1a) : ~te[exp_w];

  assign ms  = sel ? m2a : m1a;
  assign mi  = sel ? m1a : m2a;
  assign es  = sel ? e2a : e1a;
  assign ss  = sel ? rs2[sign_bit] : rs1[sign_bit];
  assign mia = {mi, 31'b0} >> de;

  logic             st1_same;
  logic             st1_neg;
  logic             st1_ss;
  logic [man_w+1:0] st1_ms;
  logic [exp_w-1:0] st1_es;
  logic [55:0]      st1_mia;

  always_ff @(posedge clk) begin
    if (accepted) begin
      st1_same <= (rs1[sign_bit] == rs2[sign_bit]);
      st1_neg  <= rs1[sign_bit] & rs2[sign_bit];
      st1_ss   <= ss;
      st1_ms   <= ms;
      st1_es   <= es;
      st1_mia  <= mia;
    end
  end

  // stage two: add or subtract, renormalize
  logic             tstck;
  logic [26:0]      mye;
  logic [exp_w-1:0] eyd;
  logic [26:0]      myd;
  logic             stck;

  assign tstck = |st1_mia[28:0];
  assign mye   = st1_same ? ({st1_ms, 2'b00} + st1_mia[55:29])
                          : ({st1_ms, 2'b00} - st1_mia[55:29]);
  assign eyd   = mye[26] ? (st1_es + 1'b1) : st1_es;
  assign myd   = mye[26] ? (mye >> 1) : mye;
  assign stck  = tstck | (mye[26] & mye[0]);

  logic [exp_w-1:0] st2_ey;
  logic [26:0]      st2_my;
  logic [4:0]       st2_se;
  logic             st2_stck;
  logic             st2_same;
  logic             st2_neg;
  logic             st2_ss;

  always_ff @(posedge clk) begin
    if (ld2) begin
      st2_ey   <= eyd;
      st2_my   <= myd;
      st2_se   <= lead_shift(myd);
      st2_stck <= stck;
      st2_same <= st1_same;
      st2_neg  <= st1_neg;
      st2_ss   <= st1_ss;
    end
  end

  // stage three: final shift and round
  logic signed [exp_w:0] eyf;
  logic [exp_w-1:0]      eyr;
  logic [exp_w-1:0]      eyri;
  logic [26:0]           myf;
  logic                  rnd_up;
  logic [man_w+1:0]      myr;
  logic [exp_w-1:0]      ey;
  logic [man_w-1:0]      my;
  logic                  sy;

  assign eyf = {1'b0, st2_ey} - {4'b0000, st2_se};
  assign eyr = (eyf > 0) ? eyf[exp_w-1:0] : '0;
  // subnormal result when the shift would take the exponent below one
  assign myf = (eyf > 0) ? (st2_my << st2_se) : (st2_my << (st2_ey[4:0] - 5'd1));

  // guard myf[1], round myf[0]; a sticky under subtraction sits below half
  assign rnd_up = myf[1] & (myf[0] | (~st2_stck & myf[2]) | (st2_stck & st2_same));
  assign myr    = myf[26:2] + {24'b0, rnd_up};
  assign eyri   = eyr + 1'b1;

  assign ey = myr[24] ? eyri :
              myr[23] ? ((eyr == '0) ? exp_w'(1) : eyr) : '0;
  assign my = myr[24] ? '0 : myr[man_w-1:0];
  // exact zero is negative only for two negative operands
  assign sy = ((ey == '0) && (my == '0)) ? st2_neg : st2_ss;

  always_ff @(posedge clk) begin
    if (ld3) begin
      rd <= {sy, ey, my};
    end
  end

endmodule

//--- rtl/fmul.sv
`timescale 1ns/1ps

module fmul
  import fpu_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              order,
  output logic              accepted,
  output logic              done,
  input  logic              grant,
  input  logic [word_w-1:0] rs1,
  input  logic [word_w-1:0] rs2,
  output logic [word_w-1:0] rd
);

  logic busy;
  logic cnt;
  logic ld2;

  assign accepted = ~busy & order;
  assign done     = busy & (cnt == 1'(fmul_stages - 1));
  assign ld2      = busy & (cnt == 1'b0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy <= 1'b0;
      cnt  <= 1'b0;
    end else if (accepted) begin
      busy <= 1'b1;
      cnt  <= 1'b0;
    end else if (done) begin
      if (grant) begin
        busy <= 1'b0;
        cnt  <= 1'b0;
      end
    end else if (busy) begin
      cnt <= 1'b1;
    end
  end

  // stage one: flush, exponent sum, mantissa product
  logic [exp_w-1:0]     e1;
  logic [exp_w-1:0]     e2;
  logic [2*man_w+1:0]   prod;
  logic [exp_w+1:0]     esum;

  assign e1   = rs1[exp_lsb +: exp_w];
  assign e2   = rs2[exp_lsb +: exp_w];
  assign prod = {1'b1, rs1[man_w-1:0]} * {1'b1, rs2[man_w-1:0]};
  // bias is half the all-ones exponent
  assign esum = {2'b00, e1} + {2'b00, e2} - 10'(exp_max >> 1);

  logic                    st1_sign;
  logic                    st1_zero;
  logic signed [exp_w+1:0] st1_exp;
  logic [2*man_w+1:0]      st1_prod;

  always_ff @(posedge clk) begin
    if (accepted) begin
      st1_sign <= rs1[sign_bit] ^ rs2[sign_bit];
      st1_zero <= (e1 == '0) | (e2 == '0);
      st1_exp  <= esum;
      st1_prod <= prod;
    end
  end

  // stage two: normalize by one place at most, round to nearest even
  logic                    hi;
  logic [man_w:0]          nm;
  logic                    guard;
  logic                    sticky;
  logic                    rup;
  logic [man_w+1:0]        mr;
  logic signed [exp_w+1:0] ex;
  logic [man_w-1:0]        frac;
  logic [word_w-1:0]       res;

  assign hi     = st1_prod[2*man_w+1];
  assign nm     = hi ? st1_prod[2*man_w+1:man_w+1] : st1_prod[2*man_w:man_w];
  assign guard  = hi ? st1_prod[man_w] : st1_prod[man_w-1];
  assign sticky = hi ? (|st1_prod[man_w-1:0]) : (|st1_prod[man_w-2:0]);
  assign rup    = guard & (sticky | nm[0]);
  assign mr     = {1'b0, nm} + {{(man_w+1){1'b0}}, rup};
  // a carry out of rounding leaves an all-zero fraction
  assign ex     = st1_exp + {{(exp_w+1){1'b0}}, hi} + {{(exp_w+1){1'b0}}, mr[man_w+1]};
  assign frac   = mr[man_w+1] ? '0 : mr[man_w-1:0];

  always_comb begin
    if (st1_zero || (ex <= 0)) begin
      res = {st1_sign, {(word_w-1){1'b0}}};
    end else if (ex >= exp_max) begin
      res = {st1_sign, exp_w'(exp_max), {man_w{1'b0}}};
    end else begin
      res = {st1_sign, ex[exp_w-1:0], frac};
    end
  end

  always_ff @(posedge clk) begin
    if (ld2) begin
      rd <= res;
    end
  end

endmodule

//--- rtl/fpu_wb_arbiter.sv
`timescale 1ns/1ps

module fpu_wb_arbiter
  import fpu_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              add_done,
  input  logic              mul_done,
  input  logic [word_w-1:0] add_rd,
  input  logic [word_w-1:0] mul_rd,
  output logic              add_grant,
  output logic              mul_grant,
  output logic              result_valid,
  output logic [word_w-1:0] result,
  output logic              result_tag
);

  logic [unit_n-1:0] req;
  logic [unit_n-1:0] gnt;
  // tag of the unit granted last
  logic              last;

  assign req = {mul_done, add_done};

  // on a conflict the unit not granted last time wins
  assign gnt[tag_add] = req[tag_add] & (~req[tag_mul] | (last == tag_mul));
  assign gnt[tag_mul] = req[tag_mul] & (~req[tag_add] | (last == tag_add));

  assign add_grant    = gnt[tag_add];
  assign mul_grant    = gnt[tag_mul];
  assign result_valid = |gnt;
  assign result       = gnt[tag_mul] ? mul_rd : add_rd;
  assign result_tag   = gnt[tag_mul] ? tag_mul : tag_add;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      // adder goes first after reset
      last <= tag_mul;
    end else if (|gnt) begin
      last <= gnt[tag_mul] ? tag_mul : tag_add;
    end
  end

endmodule

//--- rtl/fpu_cluster.sv
`timescale 1ns/1ps

module fpu_cluster
  import fpu_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              order,
  input  logic              op,
  input  logic [word_w-1:0] rs1,
  input  logic [word_w-1:0] rs2,
  output logic              accepted,
  output logic              result_valid,
  output logic [word_w-1:0] result,
  output logic              result_tag
);

  logic              add_order;
  logic              mul_order;
  logic              add_accepted;
  logic              mul_accepted;
  logic              add_done;
  logic              mul_done;
  logic              add_grant;
  logic              mul_grant;
  logic [word_w-1:0] add_rd;
  logic [word_w-1:0] mul_rd;

  // only the unit named by op sees the request
  assign add_order = order & (op == tag_add);
  assign mul_order = order & (op == tag_mul);
  assign accepted  = add_accepted | mul_accepted;

  fadd u_fadd (
    .clk      (clk),
    .rstn     (rstn),
    .order    (add_order),
    .accepted (add_accepted),
    .done     (add_done),
    .grant    (add_grant),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (add_rd)
  );

  fmul u_fmul (
    .clk      (clk),
    .rstn     (rstn),
    .order    (mul_order),
    .accepted (mul_accepted),
    .done     (mul_done),
    .grant    (mul_grant),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (mul_rd)
  );

  fpu_wb_arbiter u_arb (
    .clk          (clk),
    .rstn         (rstn),
    .add_done     (add_done),
    .mul_done     (mul_done),
    .add_rd       (add_rd),
    .mul_rd       (mul_rd),
    .add_grant    (add_grant),
    .mul_grant    (mul_grant),
    .result_valid (result_valid),
    .result       (result),
    .result_tag   (result_tag)
  );

endmodule

//--- sim/fpu_cluster_chk.sv
`timescale 1ns/1ps

module fpu_cluster_chk
  import fpu_pkg::*;
(
  input logic              clk,
  input logic              rstn,
  input logic              add_accepted,
  input logic              mul_accepted,
  input logic              add_done,
  input logic              mul_done,
  input logic              add_grant,
  input logic              mul_grant,
  input logic [word_w-1:0] add_rd,
  input logic [word_w-1:0] mul_rd
);

  a_add_grant: assert property (@(posedge clk) disable iff (!rstn) add_grant |-> add_done)
    else $error("adder granted while not done");
  a_mul_grant: assert property (@(posedge clk) disable iff (!rstn) mul_grant |-> mul_done)
    else $error("multiplier granted while not done");

  a_one_grant: assert property (@(posedge clk) disable iff (!rstn) !(add_grant && mul_grant))
    else $error("both units granted at once");

  // done rises a fixed number of edges after acceptance
  a_add_lat: assert property (@(posedge clk) disable iff (!rstn)
    add_accepted |-> ##fadd_stages $rose(add_done))
    else $error("adder latency wrong");
  a_mul_lat: assert property (@(posedge clk) disable iff (!rstn)
    mul_accepted |-> ##fmul_stages $rose(mul_done))
    else $error("multiplier latency wrong");

  a_add_hold: assert property (@(posedge clk) disable iff (!rstn)
    (add_done && !add_grant) |=> $stable(add_rd))
    else $error("adder result moved while waiting for grant");
  a_mul_hold: assert property (@(posedge clk) disable iff (!rstn)
    (mul_done && !mul_grant) |=> $stable(mul_rd))
    else $error("multiplier result moved while waiting for grant");

endmodule

bind fpu_cluster fpu_cluster_chk u_chk (
  .clk          (clk),
  .rstn         (rstn),
  .add_accepted (add_accepted),
  .mul_accepted (mul_accepted),
  .add_done     (add_done),
  .mul_done     (mul_done),
  .add_grant    (add_grant),
  .mul_grant    (mul_grant),
  .add_rd       (add_rd),
  .mul_rd       (mul_rd)
);

//--- sim/fpu_cluster_tb.sv
`timescale 1ns/1ps

module fpu_cluster_tb
  import fpu_pkg::*;
();

  localparam int n_ops     = 161;
  localparam int wd_cycles = n_ops * 20 + 200;

  logic              clk;
  logic              rstn;
  logic              order;
  logic              op;
  logic [word_w-1:0] rs1;
  logic [word_w-1:0] rs2;
  logic              accepted;
  logic              result_valid;
  logic [word_w-1:0] result;
  logic              result_tag;

  logic [word_w-1:0] add_q[$];
  logic [word_w-1:0] mul_q[$];
  logic [word_w-1:0] want;
  logic [31:0]       rng;
  logic              last_tag;
  logic              loser_due;
  logic              loser_tag;
  logic              win_tag;
  int                n_checks;
  int                n_errors;
  int                err_mark;
  int                add_seen;
  int                conflicts;
  int                waits;
  int                mark;

  fpu_cluster DUT (
    .clk          (clk),
    .rstn         (rstn),
    .order        (order),
    .op           (op),
    .rs1          (rs1),
    .rs2          (rs2),
    .accepted     (accepted),
    .result_valid (result_valid),
    .result       (result),
    .result_tag   (result_tag)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // normal operand, exponent near the middle so sums and products stay normal
  function automatic logic [31:0] mid_operand(input logic [31:0] r);
    return {r[31], 8'(100 + r[7:0] % 55), r[30:8]};
  endfunction

  function automatic real to_real(input logic [31:0] f);
    real v;
    if (f[30:23] != 8'd0) begin
      return $bitstoreal({f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'd0});
    end
    // subnormal, fraction times 2**-149
    v = $itor(f[22:0]) * $bitstoreal(64'h36a0_0000_0000_0000);
    return f[31] ? -v : v;
  endfunction

  // double to single, nearest even; ftz flushes a tiny result to zero
  function automatic logic [31:0] to_single(input real r, input logic ftz);
    logic [63:0] d;
    logic [63:0] m;
    logic [63:0] kept;
    logic [63:0] rest;
    logic [63:0] half;
    int          e;
    int          sh;
    d = $realtobits(r);
    if (d[62:0] == 63'd0) begin
      return {d[63], 31'd0};
    end
    m  = {11'd0, 1'b1, d[51:0]};
    e  = int'(d[62:52]) - 896;
    sh = (ftz || e >= 1) ? 29 : 30 - e;
    if (sh > 54) begin
      sh = 54;
    end
    kept = m >> sh;
    rest = m & ((64'd1 << sh) - 64'd1);
    half = 64'd1 << (sh - 1);
    if (rest > half || (rest == half && kept[0])) begin
      kept = kept + 64'd1;
    end
    if (!ftz && e < 1) begin
      return {d[63], 7'd0, kept[23], kept[22:0]};
    end
    if (kept[24]) begin
      kept = kept >> 1;
      e    = e + 1;
    end
    if (e >= exp_max) begin
      return {d[63], 8'hff, 23'd0};
    end
    if (e < 1) begin
      return {d[63], 31'd0};
    end
    return {d[63], e[7:0], kept[22:0]};
  endfunction

  function automatic logic [31:0] ref_fpu(input logic o, input logic [31:0] a,
                                          input logic [31:0] b);
    if (o == tag_add) begin
      return to_single(to_real(a) + to_real(b), 1'b0);
    end
    if (a[30:23] == 8'd0 || b[30:23] == 8'd0) begin
      return {a[31] ^ b[31], 31'd0};
    end
    return to_single(to_real(a) * to_real(b), 1'b1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_v);
    n_checks++;
    if (got !== exp_v) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp_v);
      n_errors++;
    end
  endtask

  // called on a falling edge; holds the request until accepted
  task automatic issue(input logic o, input logic [31:0] a, input logic [31:0] b);
    order = 1'b1;
    op    = o;
    rs1   = a;
    rs2   = b;
    waits = 0;
    #1;
    while (!accepted) begin
      @(negedge clk);
      #1;
      waits++;
    end
    if (o == tag_add) begin
      add_q.push_back(ref_fpu(o, a, b));
    end else begin
      mul_q.push_back(ref_fpu(o, a, b));
    end
    @(negedge clk);
    order = 1'b0;
  endtask

  task automatic random_op(input logic o);
    logic [31:0] a;
    rng = xorshift(rng);
    a   = mid_operand(rng);
    rng = xorshift(rng);
    issue(o, a, mid_operand(rng));
  endtask

  task automatic finish_test(input string name);
    while (add_q.size() != 0 || mul_q.size() != 0) begin
      @(negedge clk);
    end
    // a few more cycles to catch a duplicated result
    repeat (4) @(negedge clk);
    $display("test %s: %0d errors", name, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  task automatic take_result();
    if (result_tag == tag_add) begin
      add_seen++;
      if (add_q.size() == 0) begin
        $display("adder result arrived with no request pending");
        n_errors++;
      end else begin
        want = add_q.pop_front();
        check_value("result", result, want);
      end
    end else if (mul_q.size() == 0) begin
      $display("multiplier result arrived with no request pending");
      n_errors++;
    end else begin
      want = mul_q.pop_front();
      check_value("result", result, want);
    end
  endtask

  // result port is stable on the falling edge
  always @(negedge clk) begin
    if (rstn) begin
      if (loser_due && !(result_valid && result_tag == loser_tag)) begin
        $display("held result was not granted in the cycle after a conflict");
        n_errors++;
      end
      loser_due = 1'b0;
      if (DUT.add_done && DUT.mul_done) begin
        conflicts++;
        win_tag   = !last_tag;
        loser_tag = last_tag;
        loser_due = 1'b1;
        check_value("result_tag", {31'd0, result_tag}, {31'd0, win_tag});
      end
      if (result_valid) begin
        last_tag = result_tag;
        take_result();
      end
    end
  end

  initial begin
    #(wd_cycles * 10);
    $display("watchdog expired before all results came back");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rstn      = 1'b0;
    order     = 1'b0;
    op        = 1'b0;
    rs1       = '0;
    rs2       = '0;
    rng       = 32'hbc6e_66f2;
    last_tag  = tag_mul;
    loser_due = 1'b0;
    loser_tag = 1'b0;
    win_tag   = 1'b0;
    n_checks  = 0;
    n_errors  = 0;
    err_mark  = 0;
    add_seen  = 0;
    conflicts = 0;
    repeat (3) @(negedge clk);
    rstn = 1'b1;

    issue(tag_add, 32'h3fc0_0000, 32'h4010_0000);
    issue(tag_add, 32'h3f80_0000, 32'hbf00_0001);
    issue(tag_add, 32'h4b00_0000, 32'h3f00_0001);
    issue(tag_add, 32'h3f80_0000, 32'hb380_0001);
    issue(tag_add, 32'h3f80_0000, 32'h2e80_0000);
    issue(tag_add, 32'h4049_0fdb, 32'hc049_0fdb);
    issue(tag_add, 32'h8000_0000, 32'h8000_0000);
    finish_test("directed adds");

    issue(tag_mul, 32'h3fc0_0000, 32'h4000_0000);
    // rounds up into the next binade
    issue(tag_mul, 32'h3f80_0001, 32'h3fff_fffe);
    issue(tag_mul, 32'h7f00_0000, 32'h4000_0000);
    issue(tag_mul, 32'hff00_0000, 32'h4040_0000);
    issue(tag_mul, 32'h0040_0000, 32'h4000_0000);
    issue(tag_mul, 32'h0040_0000, 32'hc000_0000);
    issue(tag_mul, 32'h0100_0000, 32'h0100_0000);
    finish_test("directed multiplies");

    repeat (40) random_op(tag_add);
    repeat (40) random_op(tag_mul);
    finish_test("random back-to-back");

    mark = conflicts;
    repeat (60) begin
      rng = xorshift(rng);
      random_op(rng[3]);
    end
    if (conflicts == mark) begin
      $display("interleaved test never had both units finish in the same cycle");
      n_errors++;
    end
    finish_test("interleaved");

    mark = add_seen;
    random_op(tag_add);
    random_op(tag_add);
    if (waits == 0 || add_seen == mark) begin
      $display("second add was accepted while the adder was still busy");
      n_errors++;
    end
    random_op(tag_add);
    mark = add_seen;
    random_op(tag_mul);
    random_op(tag_add);
    if (waits == 0 || add_seen == mark) begin
      $display("add behind a conflict was accepted while the adder was still busy");
      n_errors++;
    end
    random_op(tag_mul);
    random_op(tag_mul);
    if (waits == 0) begin
      $display("second multiply was accepted while the multiplier was still busy");
      n_errors++;
    end
    finish_test("busy unit");

    $display("checks %0d, errors %0d, conflicts %0d", n_checks, n_errors, conflicts);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- files.f
rtl/fpu_pkg.sv
rtl/fadd.sv
rtl/fmul.sv
rtl/fpu_wb_arbiter.sv
rtl/fpu_cluster.sv
sim/fpu_cluster_chk.sv
sim/fpu_cluster_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module fpu_cluster_tb \
  -f files.f -o fpu_cluster_sim
status=0
out=$(./obj_dir/fpu_cluster_sim) || status=$?
printf '%s\n' "$out"
if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
  exit 0
fi
exit 1
